/* build.f */
hw/core_cfg_pkg.sv
hw/isa_pkg.sv
hw/issue_split.sv
hw/regfile.sv
hw/alu_lane.sv
hw/commit_unit.sv
hw/dual_issue_core.sv
+incdir+testbench
testbench/tb_dual_issue.sv

/* hw/alu_lane.sv */
// Execute lane
// Decodes one issued instruction, reads its sources and
// produces the retire record for the commit stage

`timescale 1ns/1ps

module alu_lane import core_cfg_pkg::*; import isa_pkg::*; #(
    parameter int LANE_ID = 1
) (
    input  issue_t                                       issue_i,
    output reg_addr_t [2*LANE_ID-1:2*LANE_ID-2]          raddr_o,
    input  word_t     [2*LANE_ID-1:2*LANE_ID-2]          rdata_i,
    output commit_t                                      result_o
);

    // Read port numbers as seen by the register file
    localparam int RS_PORT = 2 * LANE_ID - 2;
    localparam int RT_PORT = 2 * LANE_ID - 1;

    word_t    inst;
    decoded_t dec;
    word_t    src_a, src_b;
    word_t    result;

    assign inst = issue_i.inst;

    assign raddr_o[RS_PORT] = inst[25:21];
    assign raddr_o[RT_PORT] = inst[20:16];

    //////////////////////////////////////////////////
    // Decode
    always_comb begin
        dec.op      = ALU_NONE;
        dec.use_imm = 1'b1;
        dec.dest    = inst[20:16];
        dec.imm     = {16'h0000, inst[15:0]};
        case (opcode_e'(inst[31:26]))
            SPECIAL: begin
                dec.use_imm = 1'b0;
                dec.dest    = inst[15:11];
                case (funct_e'(inst[5:0]))
                    ADDU:    dec.op = ALU_ADD;
                    SUBU:    dec.op = ALU_SUB;
                    AND:     dec.op = ALU_AND;
                    OR:      dec.op = ALU_OR;
                    XOR:     dec.op = ALU_XOR;
                    NOR:     dec.op = ALU_NOR;
                    SLT:     dec.op = ALU_SLT;
                    SLTU:    dec.op = ALU_SLTU;
                    SLL:     dec.op = ALU_SLL;
                    SRL:     dec.op = ALU_SRL;
                    default: dec.op = ALU_NONE;
                endcase
            end
            ADDIU: begin
                dec.op  = ALU_ADD;
                dec.imm = {{16{inst[15]}}, inst[15:0]};
            end
            ANDI:    dec.op = ALU_AND;
            ORI:     dec.op = ALU_OR;
            XORI:    dec.op = ALU_XOR;
            LUI:     dec.op = ALU_LUI;
            default: dec.op = ALU_NONE;
        endcase
    end

    //////////////////////////////////////////////////
    // Execute
    assign src_a = rdata_i[RS_PORT];
    assign src_b = dec.use_imm ? dec.imm : rdata_i[RT_PORT];

    always_comb begin
        case (dec.op)
            ALU_ADD:  result = src_a + src_b;
            ALU_SUB:  result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_NOR:  result = ~(src_a | src_b);
            ALU_SLT:  result = word_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU: result = word_t'(src_a < src_b);
            ALU_SLL:  result = src_b << inst[10:6];
            ALU_SRL:  result = src_b >> inst[10:6];
            ALU_LUI:  result = {dec.imm[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    assign result_o.pc    = issue_i.pc;
    assign result_o.wen   = issue_i.valid && (dec.op != ALU_NONE) && (dec.dest != '0);
    assign result_o.waddr = dec.dest;
    assign result_o.wdata = result;

endmodule

/* hw/commit_unit.sv */
// Commit stage
// Registers both lane results as the retired pair. These
// records drive the register file write ports and the
// commit outputs.

`timescale 1ns/1ps

module commit_unit import core_cfg_pkg::*; (
    input  logic    clk,
    input  logic    arst_n_i,
    input  commit_t res1_i,
    input  commit_t res2_i,
    output commit_t commit1_o,
    output commit_t commit2_o
);

    commit_t commit1_q, commit2_q;
    commit_t res1_masked;
    logic    same_dest;

    // Younger instruction owns a shared destination
    assign same_dest = res1_i.wen && res2_i.wen && (res1_i.waddr == res2_i.waddr);

    always_comb begin
        res1_masked = res1_i;
        if (same_dest) begin
            res1_masked.wen = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit1_q <= '0;
            commit2_q <= '0;
        end else begin
            commit1_q <= res1_masked;
            commit2_q <= res2_i;
        end
    end

    assign commit1_o = commit1_q;
    assign commit2_o = commit2_q;

endmodule

/* hw/core_cfg_pkg.sv */
// Core configuration
// Word and register widths, plus the records that move
// between the issue stage, the lanes and the commit stage

package core_cfg_pkg;

    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // One retired instruction, also a register file write port
    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } commit_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } issue_t;

endpackage

/* hw/dual_issue_core.sv */
// Dual-issue integer execute core
// Issue stage, shared register file, two execute lanes
// and the commit stage that writes back and reports retires

`timescale 1ns/1ps

module dual_issue_core import core_cfg_pkg::*; (
    input  logic    clk,
    input  logic    arst_n_i,
    input  logic    pair_valid_i,
    input  word_t   pc_i,
    input  word_t   inst1_i,
    input  word_t   inst2_i,
    output logic    pair_ready_o,
    output commit_t commit1_o,
    output commit_t commit2_o
);

    issue_t          issue1, issue2;
    reg_addr_t [3:0] rf_raddr;
    word_t     [3:0] rf_rdata;
    commit_t         res1, res2;
    commit_t         commit1, commit2;

    issue_split u_issue (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pair_valid_i (pair_valid_i),
        .pc_i         (pc_i),
        .inst1_i      (inst1_i),
        .inst2_i      (inst2_i),
        .pair_ready_o (pair_ready_o),
        .issue1_o     (issue1),
        .issue2_o     (issue2)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_i  (rf_raddr),
        .rdata_o  (rf_rdata),
        .wr1_i    (commit1),
        .wr2_i    (commit2)
    );

    //////////////////////////////////////////////////
    // Lanes, each owns two register file read ports
    alu_lane #(.LANE_ID(1)) u_lane1 (
        .issue_i  (issue1),
        .raddr_o  (rf_raddr[1:0]),
        .rdata_i  (rf_rdata[1:0]),
        .result_o (res1)
    );

    alu_lane #(.LANE_ID(2)) u_lane2 (
        .issue_i  (issue2),
        .raddr_o  (rf_raddr[3:2]),
        .rdata_i  (rf_rdata[3:2]),
        .result_o (res2)
    );

    commit_unit u_commit (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .res1_i    (res1),
        .res2_i    (res2),
        .commit1_o (commit1),
        .commit2_o (commit2)
    );

    assign commit1_o = commit1;
    assign commit2_o = commit2;

endmodule

/* hw/isa_pkg.sv */
// MIPS32 integer subset
// Primary opcodes, SPECIAL function codes and the internal
// ALU operations used by the execute lanes

package isa_pkg;

    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        ADDIU   = 6'h09,
        ANDI    = 6'h0c,
        ORI     = 6'h0d,
        XORI    = 6'h0e,
        LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a,
        SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Decoder output of one lane
    typedef struct packed {
        alu_op_e                   op;
        logic                      use_imm;
        core_cfg_pkg::reg_addr_t   dest;
        core_cfg_pkg::word_t       imm;
    } decoded_t;

endpackage

/* hw/issue_split.sv */
// Issue stage
// Registers an accepted instruction pair into the two lanes.
// A pair whose second instruction reads the first one's result
// is issued as two single instructions on consecutive cycles.

`timescale 1ns/1ps

module issue_split import core_cfg_pkg::*; import isa_pkg::*; (
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   pair_valid_i,
    input  word_t  pc_i,
    input  word_t  inst1_i,
    input  word_t  inst2_i,
    output logic   pair_ready_o,
    output issue_t issue1_o,
    output issue_t issue2_o
);

    // Register written by an instruction, zero if none
    function automatic reg_addr_t dest_of(word_t inst);
        reg_addr_t dest;
        dest = '0;
        case (opcode_e'(inst[31:26]))
            SPECIAL: begin
                case (funct_e'(inst[5:0]))
                    ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL: dest = inst[15:11];
                    default: dest = '0;
                endcase
            end
            ADDIU, ANDI, ORI, XORI, LUI: dest = inst[20:16];
            default: dest = '0;
        endcase
        return dest;
    endfunction

    issue_t    issue1_q, issue2_q, defer_q;
    issue_t    slot1, slot2;
    reg_addr_t dest1;
    logic      rtype2;
    logic      split;

    assign slot1 = '{valid: 1'b1, pc: pc_i, inst: inst1_i};
    assign slot2 = '{valid: 1'b1, pc: pc_i + word_t'(4), inst: inst2_i};

    // RAW hazard inside the pair
    assign dest1  = dest_of(inst1_i);
    assign rtype2 = opcode_e'(inst2_i[31:26]) == SPECIAL;
    assign split  = (dest1 != '0) &&
                    ((inst2_i[25:21] == dest1) || (rtype2 && inst2_i[20:16] == dest1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue1_q <= '0;
            issue2_q <= '0;
            defer_q  <= '0;
        end else if (defer_q.valid) begin
            // Second half of a split pair, lane 1 idles
            issue1_q.valid <= 1'b0;
            issue2_q       <= defer_q;
            defer_q.valid  <= 1'b0;
        end else if (pair_valid_i) begin
            issue1_q <= slot1;
            if (split) begin
                issue2_q.valid <= 1'b0;
                defer_q        <= slot2;
            end else begin
                issue2_q <= slot2;
            end
        end else begin
            issue1_q.valid <= 1'b0;
            issue2_q.valid <= 1'b0;
        end
    end

    assign pair_ready_o = !defer_q.valid;
    assign issue1_o     = issue1_q;
    assign issue2_o     = issue2_q;

endmodule

/* hw/regfile.sv */
// General purpose register file
// 32 words, four combinational read ports, two write ports.
// Reads see same-cycle writes, lane 2 has priority.

`timescale 1ns/1ps

module regfile import core_cfg_pkg::*; (
    input  logic                clk,
    input  logic                arst_n_i,
    input  reg_addr_t [3:0]     raddr_i,
    output word_t     [3:0]     rdata_o,
    input  commit_t             wr1_i,
    input  commit_t             wr2_i
);

    word_t regs_q [NUM_REGS];

    function automatic logic hit(commit_t wr, reg_addr_t addr);
        return wr.wen && (wr.waddr == addr);
    endfunction

    //////////////////////////////////////////////////
    // Write, port 2 goes last so it wins
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (wr1_i.wen && wr1_i.waddr != '0) begin
                regs_q[wr1_i.waddr] <= wr1_i.wdata;
            end
            if (wr2_i.wen && wr2_i.waddr != '0) begin
                regs_q[wr2_i.waddr] <= wr2_i.wdata;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read with write-through bypass
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else if (hit(wr2_i, raddr_i[p])) begin
                rdata_o[p] = wr2_i.wdata;
            end else if (hit(wr1_i, raddr_i[p])) begin
                rdata_o[p] = wr1_i.wdata;
            end else begin
                rdata_o[p] = regs_q[raddr_i[p]];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_dual_issue \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log
grep -qx "Finished with no errors" sim.log && exit 0 || exit 1

/* testbench/tb_pairs.svh */
// Instruction pair table for the dual-issue core testbench
// add_pair arguments are instruction 1, instruction 2,
// expected split of the pair and idle cycles after it

`ifndef TB_PAIRS_SVH
`define TB_PAIRS_SVH

task automatic build_table();
    add_pair(r_inst(F_ADDU, 9, 1, 2, 0), r_inst(F_SUBU, 10, 3, 4, 0), 0, 0);
    add_pair(r_inst(F_AND, 11, 1, 2, 0), r_inst(F_OR, 12, 3, 4, 0), 0, 0);
    add_pair(r_inst(F_XOR, 13, 5, 6, 0), r_inst(F_NOR, 14, 7, 8, 0), 0, 0);
    add_pair(r_inst(F_SLT, 15, 1, 2, 0), r_inst(F_SLTU, 16, 1, 2, 0), 0, 0);
    add_pair(r_inst(F_SLL, 17, 0, 3, 7), r_inst(F_SRL, 18, 0, 4, 13), 0, 0);
    // Extension rules
    add_pair(i_inst(O_ADDIU, 19, 1, 'hfff0), i_inst(O_ORI, 20, 2, 'h8001), 0, 0);
    add_pair(i_inst(O_LUI, 21, 0, 'ha5c3), i_inst(O_XORI, 22, 5, 'hf0f0), 0, 0);
    // Dependent pairs
    add_pair(r_inst(F_ADDU, 23, 1, 2, 0), r_inst(F_SUBU, 24, 23, 3, 0), 1, 0);
    add_pair(i_inst(O_ANDI, 25, 6, 'h0ff0), i_inst(O_ADDIU, 26, 25, 5), 1, 0);
    // Same destination, then reads of earlier results
    add_pair(r_inst(F_ADDU, 27, 1, 2, 0), r_inst(F_XOR, 27, 3, 4, 0), 0, 0);
    add_pair(r_inst(F_OR, 28, 27, 9, 0), r_inst(F_SUBU, 29, 24, 26, 0), 0, 0);
    // Register 0 and unknown encodings
    add_pair(r_inst(F_ADDU, 0, 1, 2, 0), i_inst(6'h3f, 3, 4, 'h1234), 0, 2);
    add_pair(r_inst(F_ADDU, 30, 0, 5, 0), r_inst(6'h3f, 31, 1, 2, 0), 0, 0);
    add_pair(i_inst(O_ORI, 31, 0, 'hffff), r_inst(F_SLTU, 2, 31, 28, 0), 1, 0);
endtask

`endif

/* testbench/tb_dual_issue.sv */
// Testbench for the dual-issue execute core
// Seeds registers, applies the pair table and checks every
// retired instruction against a register-level model

`timescale 1ns/1ps

module tb_dual_issue import core_cfg_pkg::*; ();

    localparam logic [5:0] F_SLL = 6'h00;
    localparam logic [5:0] F_SRL = 6'h02;
    localparam logic [5:0] F_ADDU = 6'h21;
    localparam logic [5:0] F_SUBU = 6'h23;
    localparam logic [5:0] F_AND = 6'h24;
    localparam logic [5:0] F_OR = 6'h25;
    localparam logic [5:0] F_XOR = 6'h26;
    localparam logic [5:0] F_NOR = 6'h27;
    localparam logic [5:0] F_SLT = 6'h2a;
    localparam logic [5:0] F_SLTU = 6'h2b;
    localparam logic [5:0] O_ADDIU = 6'h09;
    localparam logic [5:0] O_ANDI = 6'h0c;
    localparam logic [5:0] O_ORI = 6'h0d;
    localparam logic [5:0] O_XORI = 6'h0e;
    localparam logic [5:0] O_LUI = 6'h0f;

    logic    clk;
    logic    arst_n_i;
    logic    pair_valid_i;
    word_t   pc_i;
    word_t   inst1_i;
    word_t   inst2_i;
    logic    pair_ready_o;
    commit_t commit1_o;
    commit_t commit2_o;

    word_t   t_inst1[$];
    word_t   t_inst2[$];
    bit      t_split[$];
    int      t_gap[$];
    int      pending[$];
    int      entry_errs[$];
    commit_t exp_q[$];
    int      exp_tag[$];
    int      exp_port[$];
    int      exp_due[$];
    word_t   model_regs[NUM_REGS];
    word_t   rnd;
    int      seed;
    int      errors;
    int      checks;
    int      cycles;
    int      limit;
    int      low;
    int      exp_low;

    dual_issue_core dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pair_valid_i (pair_valid_i),
        .pc_i         (pc_i),
        .inst1_i      (inst1_i),
        .inst2_i      (inst2_i),
        .pair_ready_o (pair_ready_o),
        .commit1_o    (commit1_o),
        .commit2_o    (commit2_o)
    );

    function automatic word_t r_inst(logic [5:0] fn, int rd, int rs, int rt, int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t i_inst(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic add_pair(word_t i1, word_t i2, bit split, int gap);
        t_inst1.push_back(i1);
        t_inst2.push_back(i2);
        t_split.push_back(split);
        t_gap.push_back(gap);
        pending.push_back(2);
        entry_errs.push_back(0);
    endtask

    `include "tb_pairs.svh"

    //////////////////////////////////////////////////
    // Reference model of one instruction in program order
    function automatic commit_t model_exec(word_t inst, word_t pc);
        commit_t r;
        word_t   a;
        word_t   b;
        word_t   zimm;
        a = model_regs[inst[25:21]];
        b = model_regs[inst[20:16]];
        zimm = {16'h0000, inst[15:0]};
        r = '{pc: pc, wen: 1'b1, waddr: inst[20:16], wdata: '0};
        case (inst[31:26])
            6'h00: begin
                r.waddr = inst[15:11];
                case (inst[5:0])
                    F_ADDU: r.wdata = a + b;
                    F_SUBU: r.wdata = a - b;
                    F_AND: r.wdata = a & b;
                    F_OR: r.wdata = a | b;
                    F_XOR: r.wdata = a ^ b;
                    F_NOR: r.wdata = ~(a | b);
                    F_SLT: r.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    F_SLTU: r.wdata = (a < b) ? 32'd1 : 32'd0;
                    F_SLL: r.wdata = b << inst[10:6];
                    F_SRL: r.wdata = b >> inst[10:6];
                    default: r.wen = 1'b0;
                endcase
            end
            O_ADDIU: r.wdata = a + {{16{inst[15]}}, inst[15:0]};
            O_ANDI: r.wdata = a & zimm;
            O_ORI: r.wdata = a | zimm;
            O_XORI: r.wdata = a ^ zimm;
            O_LUI: r.wdata = {inst[15:0], 16'h0000};
            default: r.wen = 1'b0;
        endcase
        if (r.waddr == '0) begin
            r.wen = 1'b0;
        end
        return r;
    endfunction

    // Predict both retire records of an accepted pair
    task automatic accept_pair(int e);
        commit_t r1;
        commit_t r2;
        word_t   pc;
        pc = word_t'(32'h100 + 8 * e);
        r1 = model_exec(t_inst1[e], pc);
        if (r1.wen) model_regs[r1.waddr] = r1.wdata;
        r2 = model_exec(t_inst2[e], pc + 32'd4);
        // Younger write owns a shared destination
        if (!t_split[e] && r1.wen && r2.wen && r1.waddr == r2.waddr) r1.wen = 1'b0;
        if (r2.wen) model_regs[r2.waddr] = r2.wdata;
        exp_q.push_back(r1);
        exp_tag.push_back(e);
        exp_port.push_back(1);
        exp_due.push_back(cycles + 2);
        exp_q.push_back(r2);
        exp_tag.push_back(e);
        exp_port.push_back(2);
        exp_due.push_back(cycles + 2 + (t_split[e] ? 1 : 0));
    endtask

    task automatic note_error(int e);
        errors++;
        entry_errs[e]++;
    endtask

    task automatic check_port(commit_t c, int port);
        commit_t e;
        int      t;
        int      p;
        int      due;
        if (exp_q.size() == 0 || c.pc != exp_q[0].pc) begin
            // Idle, stale or empty split slot
            assert (!c.wen) else begin
                $display("commit%0d_o wrote pc %h where no retire was expected", port, c.pc);
                errors++;
            end
            return;
        end
        e = exp_q.pop_front();
        t = exp_tag.pop_front();
        p = exp_port.pop_front();
        due = exp_due.pop_front();
        checks++;
        assert (p == port) else begin
            $display("entry %0d retired on port %0d instead of port %0d", t, port, p);
            note_error(t);
        end
        assert (cycles == due) else begin
            $display("entry %0d retired on cycle %0d instead of cycle %0d", t, cycles, due);
            note_error(t);
        end
        assert (c.wen == e.wen) else begin
            $display("error commit%0d_o.wen: got %h, expected %h", port, c.wen, e.wen);
            note_error(t);
        end
        if (e.wen) begin
            assert (c.waddr == e.waddr) else begin
                $display("error commit%0d_o.waddr: got %h, expected %h", port, c.waddr, e.waddr);
                note_error(t);
            end
            assert (c.wdata == e.wdata) else begin
                $display("error commit%0d_o.wdata: got %h, expected %h", port, c.wdata, e.wdata);
                note_error(t);
            end
        end
        pending[t]--;
        if (pending[t] == 0) begin
            $display("entry %0d pc %h: %s", t, e.pc, (entry_errs[t] == 0) ? "ok" : "failed");
        end
    endtask

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Retire monitor
    always @(negedge clk) begin
        if (!arst_n_i) begin
            assert (!commit1_o.wen && !commit2_o.wen) else begin
                $display("a commit port wrote during reset");
                errors++;
            end
        end else begin
            check_port(commit1_o, 1);
            check_port(commit2_o, 2);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d records never retired", cycles, exp_q.size());
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        seed = 89329;
        errors = 0;
        checks = 0;
        cycles = 0;
        arst_n_i = 1'b0;
        pair_valid_i = 1'b0;
        pc_i = '0;
        inst1_i = '0;
        inst2_i = '0;
        for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
        // Random register seeds through LUI/ORI pairs
        for (int r = 1; r <= 8; r++) begin
            rnd = $random(seed);
            add_pair(i_inst(O_LUI, r, 0, rnd[31:16]), i_inst(O_ORI, r, r, rnd[15:0]), 1, 0);
        end
        build_table();
        limit = 3 * t_inst1.size() + 40;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        for (int e = 0; e < t_inst1.size(); e++) begin
            pair_valid_i = 1'b1;
            pc_i = word_t'(32'h100 + 8 * e);
            inst1_i = t_inst1[e];
            inst2_i = t_inst2[e];
            exp_low = (e > 0 && t_split[e-1] && t_gap[e-1] == 0) ? 1 : 0;
            low = 0;
            while (!pair_ready_o) begin
                low++;
                @(negedge clk);
            end
            assert (low == exp_low) else begin
                $display("error pair_ready_o low cycles before entry %0d: got %h, expected %h",
                         e, low, exp_low);
                note_error(e);
            end
            accept_pair(e);
            @(negedge clk);
            for (int g = 0; g < t_gap[e]; g++) begin
                pair_valid_i = 1'b0;
                @(negedge clk);
            end
        end
        pair_valid_i = 1'b0;
        while (exp_q.size() > 0) @(negedge clk);
        // A few idle cycles for the retire monitor
        repeat (4) @(negedge clk);
        $display("%0d entries, %0d checks, %0d errors", t_inst1.size(), checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
